// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := rvDecodeTb
FILELIST  := rvDecode.f
OBJDIR    := obj_dir
PASS      := TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJDIR)

// ==== rvDecode.f ====
+incdir+source
source/isaPkg.sv
source/ctrlPkg.sv
source/controlUnit.sv
source/immGen.sv
source/regFile.sv
source/decodeStage.sv
source/rvDecodeTop.sv
verif/rvDecodeTb.sv

// ==== source/controlUnit.sv ====
`timescale 1ns/10ps
`include "rvDecode_cfg.svh"

module controlUnit (
    input  logic [6:0]     opcode,
    output ctrlPkg::ctrl_t ctrl
);

    always_comb begin
        ctrl = '0; // Fields not named below stay low
        case (opcode)
            isaPkg::OP: begin
                ctrl.aluOp    = ctrlPkg::ALU_RTYPE;
                ctrl.aluSrc   = 1'b1;
                ctrl.immType  = ctrlPkg::IMM_NONE;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            isaPkg::LOAD: begin
                ctrl.aluOp    = ctrlPkg::ALU_LOAD;
                ctrl.immType  = ctrlPkg::IMM_I;
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1; // Result from memory
            end
            isaPkg::OPIMM: begin
                ctrl.aluOp    = ctrlPkg::ALU_ITYPE;
                ctrl.immType  = ctrlPkg::IMM_I;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            isaPkg::JALR: begin
                ctrl.aluOp    = ctrlPkg::ALU_JALR;
                ctrl.immType  = ctrlPkg::IMM_I;
                ctrl.rdSrc    = 1'b1; // Link address
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.branch   = 1'b1;
            end
            isaPkg::STORE: begin
                ctrl.aluOp    = ctrlPkg::ALU_STORE;
                ctrl.immType  = ctrlPkg::IMM_S;
                ctrl.memWrite = 1'b1;
            end
            isaPkg::BRANCH: begin
                ctrl.aluOp      = ctrlPkg::ALU_BRANCH;
                ctrl.aluSrc     = 1'b1; // Compare rs1 with rs2
                ctrl.pcToRegSrc = 1'b1;
                ctrl.immType    = ctrlPkg::IMM_B;
                ctrl.rdSrc      = 1'b1;
                ctrl.branch     = 1'b1;
            end
            isaPkg::AUIPC: begin
                ctrl.aluOp      = ctrlPkg::ALU_UPPER;
                ctrl.pcToRegSrc = 1'b1; // PC plus upper immediate
                ctrl.immType    = ctrlPkg::IMM_U;
                ctrl.rdSrc      = 1'b1;
                ctrl.memToReg   = 1'b1;
                ctrl.regWrite   = 1'b1;
            end
            isaPkg::LUI: begin
                ctrl.aluOp    = ctrlPkg::ALU_UPPER;
                ctrl.immType  = ctrlPkg::IMM_U;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            isaPkg::JAL: begin
                ctrl.aluOp    = ctrlPkg::ALU_UPPER;
                ctrl.immType  = ctrlPkg::IMM_J;
                ctrl.rdSrc    = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.branch   = 1'b1;
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

// ==== source/ctrlPkg.sv ====
package ctrlPkg;

    typedef logic [2:0] aluOp_t;

    // ALU operation classes
    localparam aluOp_t ALU_RTYPE  = 3'd0;
    localparam aluOp_t ALU_LOAD   = 3'd1;
    localparam aluOp_t ALU_ITYPE  = 3'd2;
    localparam aluOp_t ALU_JALR   = 3'd3;
    localparam aluOp_t ALU_STORE  = 3'd4;
    localparam aluOp_t ALU_BRANCH = 3'd5;
    localparam aluOp_t ALU_UPPER  = 3'd6; // LUI, AUIPC and JAL

    typedef enum logic [2:0] {
        IMM_I    = 3'd0,
        IMM_S    = 3'd1,
        IMM_B    = 3'd2,
        IMM_U    = 3'd3,
        IMM_J    = 3'd4,
        IMM_NONE = 3'd5
    } immType_e;

    typedef struct packed {
        aluOp_t    aluOp;
        logic      aluSrc;
        logic      pcToRegSrc;
        immType_e  immType;
        logic      rdSrc;
        logic      memToReg;
        logic      memWrite;
        logic      memRead;
        logic      regWrite;
        logic      branch;
        logic      illegal; // Opcode not recognised
    } ctrl_t;

    typedef struct packed {
        ctrl_t             ctrl;
        isaPkg::instWord_t inst;
        isaPkg::regIdx_t   rs1;
        isaPkg::regIdx_t   rs2;
        isaPkg::regIdx_t   rd;
        isaPkg::xWord_t    rs1Val;
        isaPkg::xWord_t    rs2Val;
        isaPkg::xWord_t    imm;
    } decoded_t;

endpackage

// ==== source/decodeStage.sv ====
`timescale 1ns/10ps
`include "rvDecode_cfg.svh"

module decodeStage (
    input  logic                clk,
    input  logic                arstN,
    input  logic                inValid,
    input  isaPkg::instWord_t   inInst,
    output logic                inReady,
    input  ctrlPkg::ctrl_t      ctrl,
    input  isaPkg::xWord_t      imm,
    input  isaPkg::xWord_t      rs1Val,
    input  isaPkg::xWord_t      rs2Val,
    output logic [6:0]          opcode,
    output isaPkg::regIdx_t     rs1Idx,
    output isaPkg::regIdx_t     rs2Idx,
    output isaPkg::instWord_t   inst,
    output logic                outValid,
    output ctrlPkg::decoded_t   outRec,
    input  logic                outReady
);

    isaPkg::regIdx_t   rdIdx;
    ctrlPkg::decoded_t nextRec;
    logic              accept;

    // Fixed RV32I field positions
    assign opcode = inInst[6:0];
    assign rdIdx  = inInst[11:7];
    assign rs1Idx = inInst[19:15];
    assign rs2Idx = inInst[24:20];
    assign inst   = inInst; // Immediate bits are scattered

    always_comb begin
        nextRec.ctrl   = ctrl;
        nextRec.inst   = inInst;
        nextRec.rs1    = rs1Idx;
        nextRec.rs2    = rs2Idx;
        nextRec.rd     = rdIdx;
        nextRec.rs1Val = rs1Val;
        nextRec.rs2Val = rs2Val;
        nextRec.imm    = imm;
    end

    assign inReady = !outValid || outReady; // Slot empty or draining
    assign accept  = inValid && inReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            outRec <= nextRec; // Held while stalled
        end
    end

endmodule

// ==== source/immGen.sv ====
`timescale 1ns/10ps
`include "rvDecode_cfg.svh"

module immGen (
    input  isaPkg::instWord_t  inst,
    input  ctrlPkg::immType_e  immType,
    output isaPkg::xWord_t     imm
);

    logic signBit;

    assign signBit = inst[31]; // Every format signs from bit 31

    always_comb begin
        case (immType)
            ctrlPkg::IMM_I: begin
                imm = {{20{signBit}}, inst[31:20]};
            end
            ctrlPkg::IMM_S: begin
                imm = {{20{signBit}}, inst[31:25], inst[11:7]};
            end
            ctrlPkg::IMM_B: begin
                imm = {{19{signBit}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            ctrlPkg::IMM_U: begin
                imm = {inst[31:12], 12'b0};
            end
            ctrlPkg::IMM_J: begin
                imm = {{11{signBit}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0; // R-type carries no immediate
            end
        endcase
    end

endmodule

// ==== source/isaPkg.sv ====
`include "rvDecode_cfg.svh"

package isaPkg;

    typedef logic [31:0] instWord_t; // Always 32 bits in RV32I

    typedef logic [`RV_XLEN-1:0] xWord_t;

    typedef logic [`RV_REGIDX_W-1:0] regIdx_t;

    // Major opcodes known to the decoder
    typedef enum logic [6:0] {
        OP     = 7'b0110011, // R-type
        LOAD   = 7'b0000011,
        OPIMM  = 7'b0010011, // I-type computation
        JALR   = 7'b1100111,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        AUIPC  = 7'b0010111,
        LUI    = 7'b0110111,
        JAL    = 7'b1101111
    } opcode_e;

endpackage

// ==== source/regFile.sv ====
`timescale 1ns/10ps
`include "rvDecode_cfg.svh"

module regFile (
    input  logic             clk,
    input  logic             arstN,
    input  isaPkg::regIdx_t  rdIdxA,
    input  isaPkg::regIdx_t  rdIdxB,
    output isaPkg::xWord_t   rdDataA,
    output isaPkg::xWord_t   rdDataB,
    input  logic             wrEn,
    input  isaPkg::regIdx_t  wrIdx,
    input  isaPkg::xWord_t   wrData
);

    isaPkg::xWord_t regs [`RV_NREGS];

    // x0 first, then same-cycle write, then stored value
    function automatic isaPkg::xWord_t readPort(input isaPkg::regIdx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (wrEn && (wrIdx == idx)) begin
            return wrData;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rdDataA = readPort(rdIdxA);
        rdDataB = readPort(rdIdxB);
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrIdx != '0)) begin
            regs[wrIdx] <= wrData; // x0 never written
        end
    end

endmodule

// ==== source/rvDecodeTop.sv ====
`timescale 1ns/10ps
`include "rvDecode_cfg.svh"

module rvDecodeTop (
    input  logic               clk,
    input  logic               arstN,
    input  logic               inValid,
    input  isaPkg::instWord_t  inInst,
    output logic               inReady,
    input  logic               wbEn,
    input  isaPkg::regIdx_t    wbIdx,
    input  isaPkg::xWord_t     wbData,
    output logic               outValid,
    output ctrlPkg::decoded_t  outRec,
    input  logic               outReady
);

    logic [6:0]        opcode;
    ctrlPkg::ctrl_t    ctrl;
    isaPkg::instWord_t inst;
    isaPkg::xWord_t    imm;
    isaPkg::regIdx_t   rs1Idx;
    isaPkg::regIdx_t   rs2Idx;
    isaPkg::xWord_t    rs1Val;
    isaPkg::xWord_t    rs2Val;

    controlUnit i_ctrl (
        .opcode (opcode),
        .ctrl   (ctrl)
    );

    immGen i_imm (
        .inst    (inst),
        .immType (ctrl.immType),
        .imm     (imm)
    );

    regFile i_regs (
        .clk     (clk),
        .arstN   (arstN),
        .rdIdxA  (rs1Idx),
        .rdIdxB  (rs2Idx),
        .rdDataA (rs1Val),
        .rdDataB (rs2Val),
        .wrEn    (wbEn), // Writeback straight from outside
        .wrIdx   (wbIdx),
        .wrData  (wbData)
    );

    decodeStage i_stage (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .inInst   (inInst),
        .inReady  (inReady),
        .ctrl     (ctrl),
        .imm      (imm),
        .rs1Val   (rs1Val),
        .rs2Val   (rs2Val),
        .opcode   (opcode),
        .rs1Idx   (rs1Idx),
        .rs2Idx   (rs2Idx),
        .inst     (inst),
        .outValid (outValid),
        .outRec   (outRec),
        .outReady (outReady)
    );

endmodule

// ==== source/rvDecode_cfg.svh ====
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

// Data path width of the core
`define RV_XLEN 32

// Architectural register file size
`define RV_NREGS 32

`define RV_REGIDX_W 5 // log2 of RV_NREGS

`endif

// ==== verif/rvDecodeTb.sv ====
`timescale 1ns/10ps
`include "rvDecode_cfg.svh"

module rvDecodeTb;

    localparam int N_RAND = 200; // Per random test
    localparam int LIMIT  = (12 + 2 * N_RAND) * 4 + 100; // Watchdog in cycles
    localparam logic [6:0] OPS [12] = '{isaPkg::OP, isaPkg::LOAD, isaPkg::OPIMM, isaPkg::JALR,
        isaPkg::STORE, isaPkg::BRANCH, isaPkg::AUIPC, isaPkg::LUI, isaPkg::JAL,
        7'h00, 7'h0f, 7'h7f}; // Last three unknown

    logic               clk = 1'b0;
    logic               arstN = 1'b0;
    logic               inValid = 1'b0;
    isaPkg::instWord_t  inInst = '0;
    logic               inReady;
    logic               wbEn = 1'b0;
    isaPkg::regIdx_t    wbIdx = '0;
    isaPkg::xWord_t     wbData = '0;
    logic               outValid;
    ctrlPkg::decoded_t  outRec;
    logic               outReady = 1'b1;

    isaPkg::xWord_t    shadow [`RV_NREGS] = '{default: '0};
    ctrlPkg::decoded_t expQ [$];
    ctrlPkg::decoded_t heldRec;
    logic              holding = 1'b0;
    logic              slotFull = 1'b0; // Model of the output slot
    logic              bpOn = 1'b0;
    logic [31:0]       rngState = 32'd42;
    int unsigned       errCount = 0;
    int unsigned       testsOk = 0;
    int unsigned       testsBad = 0;
    int unsigned       acceptCount = 0;
    int unsigned       stallCount = 0;
    int unsigned       outCount = 0;

    rvDecodeTop i_dut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    // Flag order aluSrc pcToRegSrc rdSrc memToReg memWrite memRead regWrite branch
    function automatic ctrlPkg::ctrl_t makeCtrl(input logic [2:0] op,
                                                input ctrlPkg::immType_e kind,
                                                input logic [7:0] f);
        ctrlPkg::ctrl_t c;
        c = '0;
        c.aluOp   = op;
        c.immType = kind;
        {c.aluSrc, c.pcToRegSrc, c.rdSrc, c.memToReg, c.memWrite, c.memRead, c.regWrite,
         c.branch} = f;
        return c;
    endfunction

    function automatic ctrlPkg::decoded_t refDecode(input isaPkg::instWord_t w,
                                                    input isaPkg::xWord_t v1,
                                                    input isaPkg::xWord_t v2);
        ctrlPkg::decoded_t r;
        logic [31:0] sx;
        r  = '0;
        sx = $signed(w) >>> 20; // I immediate with the sign spread
        case (w[6:0])
            7'b0110011: r.ctrl = makeCtrl(3'd0, ctrlPkg::IMM_NONE, 8'b1001_0010);
            7'b0000011: r.ctrl = makeCtrl(3'd1, ctrlPkg::IMM_I, 8'b0000_0110);
            7'b0010011: r.ctrl = makeCtrl(3'd2, ctrlPkg::IMM_I, 8'b0001_0010);
            7'b1100111: r.ctrl = makeCtrl(3'd3, ctrlPkg::IMM_I, 8'b0011_0011);
            7'b0100011: r.ctrl = makeCtrl(3'd4, ctrlPkg::IMM_S, 8'b0000_1000);
            7'b1100011: r.ctrl = makeCtrl(3'd5, ctrlPkg::IMM_B, 8'b1110_0001);
            7'b0010111: r.ctrl = makeCtrl(3'd6, ctrlPkg::IMM_U, 8'b0111_0010);
            7'b0110111: r.ctrl = makeCtrl(3'd6, ctrlPkg::IMM_U, 8'b0001_0010);
            7'b1101111: r.ctrl = makeCtrl(3'd6, ctrlPkg::IMM_J, 8'b0011_0011);
            default:    r.ctrl.illegal = 1'b1;
        endcase
        case (r.ctrl.immType)
            ctrlPkg::IMM_I: r.imm = sx;
            ctrlPkg::IMM_S: r.imm = {sx[31:5], w[11:7]};
            ctrlPkg::IMM_B: r.imm = {sx[31:12], w[7], w[30:25], w[11:8], 1'b0};
            ctrlPkg::IMM_U: r.imm = {w[31:12], 12'h000};
            ctrlPkg::IMM_J: r.imm = {sx[31:20], w[19:12], w[20], w[30:21], 1'b0};
            default:        r.imm = '0;
        endcase
        r.inst   = w;
        r.rs1    = w[19:15];
        r.rs2    = w[24:20];
        r.rd     = w[11:7];
        r.rs1Val = v1;
        r.rs2Val = v2;
        return r;
    endfunction

    // Same-edge writeback wins over the shadow copy
    function automatic isaPkg::xWord_t regValue(input isaPkg::regIdx_t idx);
        if (idx == '0) begin
            return '0;
        end
        return (wbEn && wbIdx == idx) ? wbData : shadow[idx];
    endfunction

    function automatic isaPkg::instWord_t randInst();
        logic [31:0] w;
        logic [31:0] pick;
        w      = nextRand();
        pick   = nextRand();
        w[6:0] = (pick[31:28] < 4'd13) ? OPS[pick[27:24] % 4'd9] : pick[6:0];
        return w;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkRecord(input string tag, input ctrlPkg::decoded_t got,
                               input ctrlPkg::decoded_t exp);
        checkValue({tag, ".ctrl"}, 32'(got.ctrl), 32'(exp.ctrl));
        checkValue({tag, ".inst"}, got.inst, exp.inst);
        checkValue({tag, ".rs1.rs2.rd"}, 32'({got.rs1, got.rs2, got.rd}),
                   32'({exp.rs1, exp.rs2, exp.rd}));
        checkValue({tag, ".rs1Val"}, got.rs1Val, exp.rs1Val);
        checkValue({tag, ".rs2Val"}, got.rs2Val, exp.rs2Val);
        checkValue({tag, ".imm"}, got.imm, exp.imm);
    endtask

    // Half the writebacks aim at rs1 of the word on the input
    task automatic driveSide(input isaPkg::instWord_t w);
        logic [31:0] r;
        r        = nextRand();
        outReady = bpOn ? (r[31:30] != 2'b00) : 1'b1;
        wbEn     = r[29];
        wbIdx    = r[28] ? w[19:15] : r[20:16];
        wbData   = nextRand();
    endtask

    task automatic sendInst(input isaPkg::instWord_t w);
        int unsigned target;
        target  = acceptCount + 1;
        inValid = 1'b1;
        inInst  = w;
        do begin
            driveSide(w);
            @(negedge clk);
        end while (acceptCount != target);
    endtask

    task automatic drain();
        inValid = 1'b0;
        while (expQ.size() != 0 || outValid) begin
            driveSide('0);
            @(negedge clk);
        end
    endtask

    task automatic endTest(input string name, input int unsigned errBefore);
        if (errCount == errBefore) begin
            $display("test %s: ok", name);
            testsOk++;
        end else begin
            $display("test %s: %0d errors", name, errCount - errBefore);
            testsBad++;
        end
    endtask

    always @(posedge clk) begin
        if (arstN) begin
            checkValue("outValid", 32'(outValid), 32'(slotFull));
            checkValue("inReady", 32'(inReady), 32'(!slotFull || outReady));
            if (inValid && inReady) begin
                expQ.push_back(refDecode(inInst, regValue(inInst[19:15]),
                                         regValue(inInst[24:20])));
                acceptCount++;
            end else if (inValid) begin
                stallCount++;
            end
            slotFull = (inValid && inReady) || (slotFull && !outReady);
            if (wbEn && wbIdx != '0) begin
                shadow[wbIdx] = wbData; // After the reads above
            end
        end
    end

    always @(posedge clk) begin
        if (arstN && outValid) begin
            if (holding) begin
                checkRecord("held outRec", outRec, heldRec);
            end
            holding = !outReady;
            heldRec = outRec;
            if (outReady && expQ.size() == 0) begin
                $display("error: a record left the stage although none was expected");
                errCount++;
            end else if (outReady) begin
                checkRecord("outRec", outRec, expQ.pop_front());
                outCount++;
            end
        end
    end

    initial begin : main
        int unsigned errBefore;
        int unsigned base;
        time start;
        logic [31:0] r;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arstN     = 1'b1;
        errBefore = errCount;
        checkValue("outValid", 32'(outValid), 32'd0);
        checkValue("inReady", 32'(inReady), 32'd1);
        endTest("reset", errBefore);

        errBefore = errCount;
        for (int i = 0; i < 12; i++) begin
            r = nextRand();
            sendInst({r[31:7], OPS[i]});
        end
        drain();
        endTest("opcodes", errBefore);

        errBefore = errCount;
        base      = stallCount;
        start     = $time;
        for (int i = 0; i < N_RAND; i++) begin
            sendInst(randInst());
        end
        drain();
        checkValue("stallCount", stallCount - base, 32'd0);
        checkValue("streamCycles", 32'(($time - start) / 20), N_RAND + 1); // One per cycle
        endTest("stream", errBefore);

        errBefore = errCount;
        base      = outCount;
        bpOn      = 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            sendInst(randInst());
        end
        drain();
        bpOn = 1'b0;
        checkValue("outCount", outCount - base, N_RAND);
        endTest("backpressure", errBefore);

        $display("summary: %0d tests ok, %0d tests failing, %0d errors",
                 testsOk, testsBad, errCount);
        if (errCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(LIMIT * 20);
        $display("error: the run timed out after %0d cycles without finishing", LIMIT);
        $display("TESTS FAILED");
        $finish;
    end

endmodule
